// File: alu_lane.sv
`timescale 1ns/1ps

module alu_lane #(
	parameter int STAGES = 1
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,
	input  c16_pkg::alu_op_e   op,
	input  c16_pkg::word_t     a,
	input  c16_pkg::word_t     b,
	input  c16_pkg::reg_idx_t  dest,
	input  c16_pkg::tag_t      tag,
	output logic               done,
	output c16_pkg::tag_t      res_tag,
	output c16_pkg::reg_idx_t  res_dest,
	output c16_pkg::word_t     result
);

	c16_pkg::word_t    alu_out;
	logic              valid_q [STAGES];
	c16_pkg::word_t    res_q   [STAGES];
	c16_pkg::reg_idx_t dest_q  [STAGES];
	c16_pkg::tag_t     tag_q   [STAGES];

	always_comb begin
		case (op)
			c16_pkg::OP_SUB: alu_out = a - b;
			default:         alu_out = a + b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= go;
			for (int i = 1; i < STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// Result travels with its tag and destination
	always_ff @(posedge clk) begin
		res_q[0]  <= alu_out;
		dest_q[0] <= dest;
		tag_q[0]  <= tag;
		for (int i = 1; i < STAGES; i++) begin
			res_q[i]  <= res_q[i-1];
			dest_q[i] <= dest_q[i-1];
			tag_q[i]  <= tag_q[i-1];
		end
	end

	assign done     = valid_q[STAGES-1];
	assign result   = res_q[STAGES-1];
	assign res_dest = dest_q[STAGES-1];
	assign res_tag  = tag_q[STAGES-1];

endmodule

// File: c16_core.sv
`timescale 1ns/1ps

module c16_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  c16_pkg::instr_t    instr,
	output logic               stall,
	output logic               commit_valid,
	output c16_pkg::reg_idx_t  commit_reg,
	output c16_pkg::word_t     commit_value
);

	c16_pkg::reg_idx_t rd_a_idx;
	c16_pkg::reg_idx_t rd_b_idx;
	c16_pkg::word_t    rd_a_value;
	c16_pkg::word_t    rd_b_value;

	c16_pkg::alu_op_e  lane_op;
	c16_pkg::word_t    lane_a;
	c16_pkg::word_t    lane_b;
	c16_pkg::reg_idx_t lane_dest;
	c16_pkg::tag_t     lane_tag;
	logic              go0;
	logic              go1;

	logic              done0;
	c16_pkg::tag_t     tag0;
	c16_pkg::reg_idx_t dest0;
	c16_pkg::word_t    result0;
	logic              done1;
	c16_pkg::tag_t     tag1;
	c16_pkg::reg_idx_t dest1;
	c16_pkg::word_t    result1;

	//////////////////////////////////////////////////
	// Producer
	//////////////////////////////////////////////////
	instr_issue u_issue (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rd_a_value   (rd_a_value),
		.rd_b_value   (rd_b_value),
		.commit_valid (commit_valid),
		.commit_reg   (commit_reg),
		.stall        (stall),
		.rd_a_idx     (rd_a_idx),
		.rd_b_idx     (rd_b_idx),
		.lane_op      (lane_op),
		.lane_a       (lane_a),
		.lane_b       (lane_b),
		.lane_dest    (lane_dest),
		.lane_tag     (lane_tag),
		.go0          (go0),
		.go1          (go1)
	);

	alu_lane #(.STAGES(c16_pkg::LANE0_STAGES)) u_lane0 ( // Short lane
		.clk(clk), .rst_n(rst_n), .go(go0), .op(lane_op), .a(lane_a), .b(lane_b),
		.dest(lane_dest), .tag(lane_tag),
		.done(done0), .res_tag(tag0), .res_dest(dest0), .result(result0)
	);

	alu_lane #(.STAGES(c16_pkg::LANE1_STAGES)) u_lane1 ( // Long lane
		.clk(clk), .rst_n(rst_n), .go(go1), .op(lane_op), .a(lane_a), .b(lane_b),
		.dest(lane_dest), .tag(lane_tag),
		.done(done1), .res_tag(tag1), .res_dest(dest1), .result(result1)
	);

	//////////////////////////////////////////////////
	// Buffer and consumer
	//////////////////////////////////////////////////
	reorder_buffer u_rob (
		.clk(clk), .rst_n(rst_n),
		.done0(done0), .tag0(tag0), .dest0(dest0), .result0(result0),
		.done1(done1), .tag1(tag1), .dest1(dest1), .result1(result1),
		.commit_valid(commit_valid), .commit_reg(commit_reg), .commit_value(commit_value)
	);

	commit_regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.commit_valid(commit_valid), .commit_reg(commit_reg), .commit_value(commit_value),
		.rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
		.rd_a_value(rd_a_value), .rd_b_value(rd_b_value)
	);

endmodule

// File: c16_core_props.sv
`timescale 1ns/1ps

module c16_core_props (
	input logic              clk,
	input logic              rst_n,
	input logic              instr_valid,
	input c16_pkg::instr_t   instr,
	input logic              stall,
	input logic              commit_valid,
	input c16_pkg::reg_idx_t commit_reg,
	input c16_pkg::word_t    commit_value
);

	// Quiet outputs once reset lifts
	reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> (!stall && !commit_valid))
		else $error("stall or commit_valid high in the first cycle after reset");

	repeat_commit: assert property (@(posedge clk) disable iff (!rst_n)
		(commit_valid && $past(commit_valid) && !$past(instr_valid && !stall))
		|-> ((commit_reg != $past(commit_reg)) || (commit_value != $past(commit_value))))
		else $error("commit repeated with the same register and value");

	held_instr: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && stall) |=> (instr_valid && $stable(instr)))
		else $error("instruction changed while stalled");

endmodule

bind c16_core c16_core_props u_props (
	.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
	.stall(stall), .commit_valid(commit_valid), .commit_reg(commit_reg),
	.commit_value(commit_value)
);

// File: c16_pkg.sv
package c16_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int WORD_W    = 16;
	localparam int REG_IDX_W = 3;
	localparam int TAG_W     = 3;
	localparam int OPC_W     = 5;
	localparam int IMM_W     = 5; // Immediate field in bits 4..0

	localparam int NUM_REGS  = 8;
	localparam int ROB_DEPTH = 8; // One entry per busy destination

	// Lane depths in register stages
	localparam int LANE0_STAGES = 1;
	localparam int LANE1_STAGES = 3;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////
	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [WORD_W-1:0]    instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [TAG_W-1:0]     tag_t;

	// Instruction bits 15..11
	typedef enum logic [OPC_W-1:0] {
		OPC_ADD_IMM = 5'b00000,
		OPC_ADD_REG = 5'b00001,
		OPC_SUB_IMM = 5'b00010,
		OPC_SUB_REG = 5'b00011
	} opcode_e;

	// Decoded lane operation
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_NOP = 2'd2
	} alu_op_e;

endpackage

// File: commit_regfile.sv
`timescale 1ns/1ps

module commit_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               commit_valid,
	input  c16_pkg::reg_idx_t  commit_reg,
	input  c16_pkg::word_t     commit_value,
	input  c16_pkg::reg_idx_t  rd_a_idx,
	input  c16_pkg::reg_idx_t  rd_b_idx,
	output c16_pkg::word_t     rd_a_value,
	output c16_pkg::word_t     rd_b_value
);

	c16_pkg::word_t regs [c16_pkg::NUM_REGS]; // Architectural state

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < c16_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (commit_valid) begin
			regs[commit_reg] <= commit_value;
		end
	end

	// Busy sources stall at issue, so plain reads suffice
	assign rd_a_value = regs[rd_a_idx];
	assign rd_b_value = regs[rd_b_idx];

endmodule

// File: instr_issue.sv
`timescale 1ns/1ps

module instr_issue (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  c16_pkg::instr_t    instr,
	input  c16_pkg::word_t     rd_a_value,
	input  c16_pkg::word_t     rd_b_value,
	input  logic               commit_valid,
	input  c16_pkg::reg_idx_t  commit_reg,
	output logic               stall,
	output c16_pkg::reg_idx_t  rd_a_idx,
	output c16_pkg::reg_idx_t  rd_b_idx,
	output c16_pkg::alu_op_e   lane_op,
	output c16_pkg::word_t     lane_a,
	output c16_pkg::word_t     lane_b,
	output c16_pkg::reg_idx_t  lane_dest,
	output c16_pkg::tag_t      lane_tag,
	output logic               go0,
	output logic               go1
);

	c16_pkg::opcode_e  opcode;
	c16_pkg::alu_op_e  op;
	c16_pkg::reg_idx_t dest;
	c16_pkg::reg_idx_t src_a;
	c16_pkg::reg_idx_t src_b;
	c16_pkg::word_t    imm;
	logic              use_imm;
	logic              is_alu;
	logic              hazard;
	logic              accept;

	logic [c16_pkg::NUM_REGS-1:0] busy; // Scoreboard, one bit per register
	c16_pkg::tag_t                tail_tag;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	assign opcode = c16_pkg::opcode_e'(instr[15:11]);
	assign dest   = instr[10:8];
	assign src_a  = instr[7:5];
	assign src_b  = instr[2:0];
	assign imm    = {{(c16_pkg::WORD_W - c16_pkg::IMM_W){instr[c16_pkg::IMM_W-1]}},
		instr[c16_pkg::IMM_W-1:0]};

	always_comb begin
		op      = c16_pkg::OP_NOP;
		use_imm = 1'b0;
		case (opcode)
			c16_pkg::OPC_ADD_IMM: begin
				op      = c16_pkg::OP_ADD;
				use_imm = 1'b1;
			end
			c16_pkg::OPC_ADD_REG: begin
				op = c16_pkg::OP_ADD;
			end
			c16_pkg::OPC_SUB_IMM: begin
				op      = c16_pkg::OP_SUB;
				use_imm = 1'b1;
			end
			c16_pkg::OPC_SUB_REG: begin
				op = c16_pkg::OP_SUB;
			end
			default: begin
				op = c16_pkg::OP_NOP; // Anything else is dropped
			end
		endcase
	end

	assign is_alu = (op != c16_pkg::OP_NOP);

	//////////////////////////////////////////////////
	// Scoreboard check
	//////////////////////////////////////////////////
	assign hazard = busy[src_a] | (~use_imm & busy[src_b]) | busy[dest];
	assign stall  = instr_valid & is_alu & hazard;
	assign accept = instr_valid & is_alu & ~hazard;

	// Operands come straight from committed state
	assign rd_a_idx = src_a;
	assign rd_b_idx = src_b;

	assign lane_op   = op;
	assign lane_a    = rd_a_value;
	assign lane_b    = use_imm ? imm : rd_b_value;
	assign lane_dest = dest;
	assign lane_tag  = tail_tag;

	// Even tags to lane 0, odd tags to lane 1
	assign go0 = accept & ~tail_tag[0];
	assign go1 = accept & tail_tag[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= '0;
			tail_tag <= '0;
		end else begin
			if (commit_valid) begin
				busy[commit_reg] <= 1'b0;
			end
			if (accept) begin
				busy[dest] <= 1'b1;
				tail_tag   <= tail_tag + 1'b1;
			end
		end
	end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               done0,
	input  c16_pkg::tag_t      tag0,
	input  c16_pkg::reg_idx_t  dest0,
	input  c16_pkg::word_t     result0,
	input  logic               done1,
	input  c16_pkg::tag_t      tag1,
	input  c16_pkg::reg_idx_t  dest1,
	input  c16_pkg::word_t     result1,
	output logic               commit_valid,
	output c16_pkg::reg_idx_t  commit_reg,
	output c16_pkg::word_t     commit_value
);

	logic [c16_pkg::ROB_DEPTH-1:0] ent_valid;
	c16_pkg::reg_idx_t             ent_dest  [c16_pkg::ROB_DEPTH];
	c16_pkg::word_t                ent_value [c16_pkg::ROB_DEPTH];
	c16_pkg::tag_t                 head; // Oldest uncommitted tag
	logic                          retire;

	assign retire = ent_valid[head];

	//////////////////////////////////////////////////
	// Entry state and head pointer
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ent_valid    <= '0;
			head         <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			if (retire) begin
				ent_valid[head] <= 1'b0;
				head            <= head + 1'b1;
			end
			// Lanes never share a tag, both may land together
			if (done0) begin
				ent_valid[tag0] <= 1'b1;
			end
			if (done1) begin
				ent_valid[tag1] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Entry payload and commit outputs
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (done0) begin
			ent_dest[tag0]  <= dest0;
			ent_value[tag0] <= result0;
		end
		if (done1) begin
			ent_dest[tag1]  <= dest1;
			ent_value[tag1] <= result1;
		end
		if (retire) begin
			commit_reg   <= ent_dest[head];
			commit_value <= ent_value[head];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_c16_core -o sim_c16

output=$(./obj_dir/sim_c16)
echo "$output"

if echo "$output" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1

// File: sources.f
c16_pkg.sv
instr_issue.sv
alu_lane.sv
reorder_buffer.sv
commit_regfile.sv
c16_core.sv
c16_core_props.sv
tb_c16_core.sv

// File: tb_c16_core.sv
`timescale 1ns/1ps

module tb_c16_core;

	localparam int CLK_PERIOD = 20;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	c16_pkg::instr_t   instr;
	logic              stall;
	logic              commit_valid;
	c16_pkg::reg_idx_t commit_reg;
	c16_pkg::word_t    commit_value;

	// Stimulus table, one entry per row
	string           row_name[$];
	c16_pkg::instr_t row_instr[$];
	bit              row_commit[$];
	bit              row_stall[$]; // Row must wait at least one cycle

	// Commits still owed, oldest first
	string             exp_name_q[$];
	c16_pkg::reg_idx_t exp_reg_q[$];
	c16_pkg::word_t    exp_value_q[$];

	c16_pkg::word_t model_regs [c16_pkg::NUM_REGS];
	logic [15:0]    lfsr_state;
	int             tests_passed = 0;
	int             tests_failed = 0;
	int             other_errors = 0;

	c16_core dut (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.stall(stall), .commit_valid(commit_valid), .commit_reg(commit_reg),
		.commit_value(commit_value)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	function automatic c16_pkg::instr_t enc_imm(c16_pkg::opcode_e opc, int d, int s, int imm);
		return {opc, d[2:0], s[2:0], imm[4:0]};
	endfunction

	function automatic c16_pkg::instr_t enc_reg(c16_pkg::opcode_e opc, int d, int s, int t);
		return {opc, d[2:0], s[2:0], 2'b00, t[2:0]};
	endfunction

	task automatic add_row(input string name, input c16_pkg::instr_t ins, input bit commits,
		input bit stalls);
		row_name.push_back(name);
		row_instr.push_back(ins);
		row_commit.push_back(commits);
		row_stall.push_back(stalls);
	endtask

	task automatic build_table();
		c16_pkg::opcode_e opc;
		int               d;
		int               s;
		c16_pkg::instr_t  ins;
		add_row("add_imm_pos", enc_imm(c16_pkg::OPC_ADD_IMM, 1, 0, 5), 1'b1, 1'b0);
		add_row("add_imm_neg", enc_imm(c16_pkg::OPC_ADD_IMM, 2, 0, -3), 1'b1, 1'b0);
		add_row("sub_imm_neg", enc_imm(c16_pkg::OPC_SUB_IMM, 3, 0, -16), 1'b1, 1'b0);
		add_row("sub_imm_pos", enc_imm(c16_pkg::OPC_SUB_IMM, 4, 0, 7), 1'b1, 1'b0);
		add_row("add_reg_wrap", enc_reg(c16_pkg::OPC_ADD_REG, 5, 1, 2), 1'b1, 1'b0);
		add_row("sub_reg_wrap", enc_reg(c16_pkg::OPC_SUB_REG, 6, 1, 3), 1'b1, 1'b0);
		add_row("add_reg_self", enc_reg(c16_pkg::OPC_ADD_REG, 7, 4, 4), 1'b1, 1'b0);
		// Each link reads the one before
		add_row("chain_0", enc_imm(c16_pkg::OPC_ADD_IMM, 1, 7, 3), 1'b1, 1'b0);
		add_row("chain_1", enc_reg(c16_pkg::OPC_ADD_REG, 2, 1, 5), 1'b1, 1'b1);
		add_row("chain_2", enc_imm(c16_pkg::OPC_SUB_IMM, 3, 2, 1), 1'b1, 1'b1);
		add_row("chain_3", enc_reg(c16_pkg::OPC_SUB_REG, 1, 3, 2), 1'b1, 1'b1);
		// Independent, so lane 1 results trail younger lane 0 ones
		add_row("ooo_0", enc_imm(c16_pkg::OPC_ADD_IMM, 4, 0, 9), 1'b1, 1'b0);
		add_row("ooo_1", enc_imm(c16_pkg::OPC_ADD_IMM, 5, 0, 10), 1'b1, 1'b0);
		add_row("ooo_2", enc_imm(c16_pkg::OPC_SUB_IMM, 6, 0, 11), 1'b1, 1'b0);
		add_row("ooo_3", enc_imm(c16_pkg::OPC_ADD_IMM, 7, 0, 15), 1'b1, 1'b0);
		add_row("undef_load", {5'b00100, 3'd2, 3'd3, 5'd4}, 1'b0, 1'b0);
		add_row("undef_high", {5'b11111, 3'd7, 3'd1, 5'd31}, 1'b0, 1'b0); // Busy dest ignored
		add_row("after_undef", enc_imm(c16_pkg::OPC_ADD_IMM, 2, 4, 1), 1'b1, 1'b0);
		for (int k = 0; k < 16; k++) begin
			opc = c16_pkg::opcode_e'(5'(rand_bits(2)));
			d   = rand_bits(3);
			s   = rand_bits(3);
			if (opc == c16_pkg::OPC_ADD_REG || opc == c16_pkg::OPC_SUB_REG) begin
				ins = enc_reg(opc, d, s, rand_bits(3));
			end else begin
				ins = enc_imm(opc, d, s, rand_bits(5));
			end
			add_row($sformatf("rand_%02d", k), ins, 1'b1, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////
	function automatic c16_pkg::word_t model_result(input c16_pkg::instr_t ins);
		c16_pkg::word_t a;
		c16_pkg::word_t b;
		a = model_regs[ins[7:5]];
		b = {{11{ins[4]}}, ins[4:0]}; // Sign-extended immediate
		if (ins[15:11] == c16_pkg::OPC_ADD_REG || ins[15:11] == c16_pkg::OPC_SUB_REG) begin
			b = model_regs[ins[2:0]];
		end
		if (ins[15:11] == c16_pkg::OPC_SUB_IMM || ins[15:11] == c16_pkg::OPC_SUB_REG) begin
			return a - b;
		end
		return a + b;
	endfunction

	task automatic check_reg(input string name, input c16_pkg::reg_idx_t expected,
		input c16_pkg::reg_idx_t actual, inout bit ok);
		if (actual !== expected) begin
			$display("mismatch %s commit_reg expected r%0d actual r%0d", name, expected, actual);
			ok = 1'b0;
		end
	endtask

	task automatic check_value(input string name, input c16_pkg::word_t expected,
		input c16_pkg::word_t actual, inout bit ok);
		if (actual !== expected) begin
			$display("mismatch %s commit_value expected 0x%04h actual 0x%04h", name, expected,
				actual);
			ok = 1'b0;
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			tests_passed++;
			$display("test %-12s ok", name);
		end else begin
			tests_failed++;
			$display("test %-12s failed", name);
		end
	endtask

	// Starts 2 ns past an edge, returns 2 ns past the acceptance edge
	task automatic present(input c16_pkg::instr_t ins, output int stalls);
		instr_valid = 1'b1;
		instr       = ins;
		stalls      = 0;
		@(negedge clk);
		while (stall) begin
			stalls++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	//////////////////////////////////////////////////
	// Processes
	//////////////////////////////////////////////////
	initial begin : commit_monitor
		string             name;
		c16_pkg::reg_idx_t exp_reg;
		c16_pkg::word_t    exp_value;
		bit                ok;
		forever begin
			@(negedge clk);
			if (rst_n && commit_valid) begin
				if (exp_name_q.size() == 0) begin
					$display("unexpected commit to r%0d with value 0x%04h", commit_reg,
						commit_value);
					other_errors++;
				end else begin
					name      = exp_name_q.pop_front();
					exp_reg   = exp_reg_q.pop_front();
					exp_value = exp_value_q.pop_front();
					ok        = 1'b1;
					check_reg(name, exp_reg, commit_reg, ok);
					check_value(name, exp_value, commit_value, ok);
					report_test(name, ok);
				end
			end
		end
	end

	initial begin : watchdog
		int limit_ns;
		wait (rst_n === 1'b1);
		limit_ns = row_name.size() * (c16_pkg::LANE1_STAGES + 12) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout after %0d ns, the core stopped issuing or committing", limit_ns);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : main
		int             stalls;
		c16_pkg::word_t value;
		instr_valid = 1'b0;
		instr       = '0;
		rst_n       = 1'b0;
		lfsr_state  = 16'd10;
		for (int r = 0; r < c16_pkg::NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		build_table();
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		for (int i = 0; i < row_name.size(); i++) begin
			if (row_commit[i]) begin
				value = model_result(row_instr[i]);
				model_regs[row_instr[i][10:8]] = value;
				exp_name_q.push_back(row_name[i]);
				exp_reg_q.push_back(row_instr[i][10:8]);
				exp_value_q.push_back(value);
			end
			present(row_instr[i], stalls);
			if (row_stall[i] && stalls == 0) begin
				$display("%s issued at once although its source register was busy",
					row_name[i]);
				other_errors++;
			end
			if (!row_commit[i]) begin
				if (stalls != 0) begin
					$display("%s was held by the scoreboard although it decodes to no operation",
						row_name[i]);
				end
				report_test(row_name[i], stalls == 0); // Accepted, owes no commit
			end
		end
		instr_valid = 1'b0;
		instr       = '0;
		while (exp_name_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (8) @(posedge clk); // Room for a stray commit
		$display("tests %0d passed, %0d failed, %0d other errors", tests_passed, tests_failed,
			other_errors);
		if (tests_failed == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
